// ==== dv/afu_core_properties.sv ====
// concurrent checks on the host request outputs of the staging core
// bound into every afu_core instance
`timescale 1ns/1ps
`default_nettype none

module afu_core_properties (
	input wire CLK_400M,
	input wire reset_n,
	input wire spl_tx_rd_almostfull,
	input wire spl_tx_wr_almostfull,
	input wire cor_tx_rd_valid,
	input wire cor_tx_wr_valid
);

	// a request only follows a cycle without almost-full
	rd_after_full: assert property (@(posedge CLK_400M) disable iff (!reset_n)
		$past(spl_tx_rd_almostfull) |-> !cor_tx_rd_valid)
		else $error("read valid one cycle after read almost-full");

	wr_after_full: assert property (@(posedge CLK_400M) disable iff (!reset_n)
		$past(spl_tx_wr_almostfull) |-> !cor_tx_wr_valid)
		else $error("write valid one cycle after write almost-full");

	// synchronous reset clears both valids at the next edge
	quiet_in_reset: assert property (@(posedge CLK_400M)
		!reset_n |=> (!cor_tx_rd_valid && !cor_tx_wr_valid))
		else $error("request valid during reset");

endmodule

bind afu_core afu_core_properties props0 (
	.CLK_400M             (CLK_400M),
	.reset_n              (reset_n),
	.spl_tx_rd_almostfull (spl_tx_rd_almostfull),
	.spl_tx_wr_almostfull (spl_tx_wr_almostfull),
	.cor_tx_rd_valid      (cor_tx_rd_valid),
	.cor_tx_wr_valid      (cor_tx_wr_valid)
);

`default_nettype wire

// ==== dv/afu_core_tb.sv ====
// directed testbench for the staging core, with a host memory model
// runs jobs through afu_core and checks reads, data writes, fences and completion
`timescale 1ns/1ps
`default_nettype none

`include "afu_core_macros.svh"

module afu_core_tb import afu_core_pkg::*; ();

	localparam line_addr_t SRC_PTR = 58'h0000_0100_0000;
	localparam line_addr_t DST_PTR = 58'h0000_2000_0000;
	localparam line_addr_t HAND_ADDR = SRC_PTR + line_addr_t'(`HAND_OFFSET);
	localparam line_addr_t INPUT_BASE = SRC_PTR + line_addr_t'(`INPUT_OFFSET);

	// per-job worst case covers settle, polls and quiet time plus slow lines
	localparam int JOB_BASE_CYCLES = 200;
	localparam int LINE_CYCLES = 12;
	localparam int WORST_CYCLES = 20 + 5 * JOB_BASE_CYCLES
		+ LINE_CYCLES * `LINES_PER_READ * (2 + 3 + 8 + 16 + 0);
	localparam int WATCHDOG_NS = 2 * WORST_CYCLES * 4;

	logic         CLK_400M = 1'b0;
	logic         reset_n;
	logic         core_start;
	logic         spl_tx_rd_almostfull;
	logic         spl_tx_wr_almostfull;
	logic         io_rx_rd_valid;
	cache_line_t  io_rx_data;
	line_addr_t   io_src_ptr;
	line_addr_t   io_dst_ptr;
	logic         cor_tx_rd_valid;
	line_addr_t   cor_tx_rd_addr;
	logic         cor_tx_wr_valid;
	logic         cor_tx_fence_valid;
	line_addr_t   cor_tx_wr_addr;
	cache_line_t  cor_tx_data;

	cache_line_t  hs_line;
	logic         expect_tag1;
	logic         bp_enable;
	logic [63:0]  delay_state;
	logic [63:0]  bp_state;
	int           cycle;
	int           value_errors;
	int           other_errors;

	// request and response logs of the host model
	line_addr_t   rd_log[$];
	line_addr_t   pend_addr[$];
	int           pend_ready[$];
	line_addr_t   wr_addr_log[$];
	cache_line_t  wr_data_log[$];
	logic         wr_fence_log[$];

	always #2 CLK_400M = ~CLK_400M;

	afu_core dut0 (.*);

	function automatic logic [63:0] xorshift64(input logic [63:0] x);
		logic [63:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 7);
		y = y ^ (y << 17);
		return y;
	endfunction

	// every word of the fill pattern mixes in the whole line address
	function automatic cache_line_t input_line(input line_addr_t addr);
		cache_line_t line;
		logic [63:0] s;
		s = {6'b0, addr} ^ 64'd6165;
		for (int k = 0; k < 8; k++) begin
			s = xorshift64(s + 64'h9e37_79b9_7f4a_7c15);
			line.raw[k*64 +: 64] = s;
		end
		return line;
	endfunction

	function automatic cache_line_t make_handshake(input logic tag0, input logic tag1,
		input batch_size_t n);
		cache_line_t line;
		line = input_line(HAND_ADDR);
		line.raw[`TAG0_BIT] = tag0;
		line.raw[`TAG1_BIT] = tag1;
		line.raw[`BATCH_LSB +: `BATCH_WIDTH] = n;
		return line;
	endfunction

	task automatic compare_line(input string name, input cache_line_t got,
		input cache_line_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Mismatch %s: got %h expected %h", name, got.raw, exp.raw);
		end
	endtask

	task automatic compare_addr(input string name, input line_addr_t got,
		input line_addr_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_count(input string name, input line_count_t got,
		input line_count_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string msg);
		other_errors++;
		$display("Error: %s", msg);
	endtask

	// ----------------------------------------
	// host memory model logs requests and answers reads in order after 1 to 4 cycles
	task automatic host_model();
		int ready;
		forever begin
			@(negedge CLK_400M);
			cycle++;
			if (cor_tx_wr_valid) begin
				wr_addr_log.push_back(cor_tx_wr_addr);
				wr_data_log.push_back(cor_tx_data);
				wr_fence_log.push_back(cor_tx_fence_valid);
			end
			if (cor_tx_rd_valid) begin
				rd_log.push_back(cor_tx_rd_addr);
				delay_state = xorshift64(delay_state);
				ready = cycle + 1 + int'(delay_state[1:0]);
				if (pend_ready.size() > 0 && ready <= pend_ready[$]) begin
					ready = pend_ready[$] + 1;
				end
				pend_addr.push_back(cor_tx_rd_addr);
				pend_ready.push_back(ready);
			end
			if (pend_ready.size() > 0 && pend_ready[0] <= cycle) begin
				io_rx_data = (pend_addr[0] == HAND_ADDR) ? hs_line : input_line(pend_addr[0]);
				io_rx_rd_valid = 1'b1;
				void'(pend_addr.pop_front());
				void'(pend_ready.pop_front());
			end else begin
				io_rx_rd_valid = 1'b0;
			end
		end
	endtask

	task automatic drive_backpressure();
		forever begin
			@(negedge CLK_400M);
			if (bp_enable) begin
				bp_state = xorshift64(bp_state);
				spl_tx_rd_almostfull = bp_state[0];
				spl_tx_wr_almostfull = bp_state[1];
			end else begin
				spl_tx_rd_almostfull = 1'b0;
				spl_tx_wr_almostfull = 1'b0;
			end
		end
	endtask

	task automatic wait_log(input bit writes, input int count, input int budget);
		int waited;
		waited = 0;
		while ((writes ? wr_addr_log.size() : rd_log.size()) < count && waited < budget) begin
			@(negedge CLK_400M);
			waited++;
		end
		if ((writes ? wr_addr_log.size() : rd_log.size()) < count) begin
			report_failure(writes ? "timed out waiting for writes" : "timed out waiting for reads");
		end
	endtask

	// polls first, then each input line once, then data, fence, completion, fence
	task automatic check_job(input int n);
		int lines;
		int polls;
		cache_line_t done_line;
		lines = n * `LINES_PER_READ;
		polls = 0;
		// completion code sits in the top bits, zeros below
		done_line.raw = '0;
		done_line.raw[`CL_WIDTH-1 -: `DONE_WIDTH] = `DONE_CODE;
		while (polls < rd_log.size() && rd_log[polls] == HAND_ADDR) begin
			polls++;
		end
		if (polls == 0) begin
			report_failure("no handshake poll before the load reads");
		end
		compare_count("cor_tx_rd_valid load count", line_count_t'(rd_log.size() - polls),
			line_count_t'(lines));
		for (int i = 0; i < lines && polls + i < rd_log.size(); i++) begin
			compare_addr("cor_tx_rd_addr", rd_log[polls + i], INPUT_BASE + line_addr_t'(i));
		end
		compare_count("cor_tx_wr_valid count", line_count_t'(wr_addr_log.size()),
			line_count_t'(lines + 3));
		if (wr_addr_log.size() != lines + 3) begin
			return;
		end
		for (int i = 0; i < lines; i++) begin
			if (wr_fence_log[i]) begin
				report_failure("fence flagged on a data write");
			end
			compare_addr("cor_tx_wr_addr", wr_addr_log[i], DST_PTR + line_addr_t'(i));
			compare_line("cor_tx_data", wr_data_log[i], input_line(INPUT_BASE + line_addr_t'(i)));
		end
		if (!wr_fence_log[lines]) begin
			report_failure("no fence after the data writes");
		end
		if (wr_fence_log[lines + 1]) begin
			report_failure("completion write flagged as a fence");
		end
		compare_addr("cor_tx_wr_addr", wr_addr_log[lines + 1], HAND_ADDR);
		compare_line("cor_tx_data", wr_data_log[lines + 1], done_line);
		if (!wr_fence_log[lines + 2]) begin
			report_failure("no fence after the completion write");
		end
	endtask

	// misses > 0 serves miss_hs until that many polls were seen
	task automatic run_job(input int n, input cache_line_t miss_hs, input int misses,
		input bit check_lead);
		int lead;
		int budget;
		budget = JOB_BASE_CYCLES + LINE_CYCLES * `LINES_PER_READ * n;
		rd_log.delete();
		wr_addr_log.delete();
		wr_data_log.delete();
		wr_fence_log.delete();
		hs_line = (misses > 0) ? miss_hs
			: make_handshake(!expect_tag1, expect_tag1, batch_size_t'(n));
		@(negedge CLK_400M);
		core_start = 1'b1;
		@(negedge CLK_400M);
		core_start = 1'b0;
		lead = 1;
		while (!cor_tx_rd_valid && lead < budget) begin
			@(negedge CLK_400M);
			lead++;
		end
		if (check_lead && lead - 1 != `SETTLE_CYCLES + 1) begin
			report_failure("first poll did not follow the settle cycles");
		end
		if (misses > 0) begin
			wait_log(1'b0, misses, budget);
			for (int i = 0; i < misses && i < rd_log.size(); i++) begin
				compare_addr("cor_tx_rd_addr", rd_log[i], HAND_ADDR);
			end
			compare_count("cor_tx_wr_valid count while polling",
				line_count_t'(wr_addr_log.size()), '0);
			hs_line = make_handshake(!expect_tag1, expect_tag1, batch_size_t'(n));
		end
		wait_log(1'b1, n * `LINES_PER_READ + 3, budget);
		// quiet time shows up late or repeated requests
		repeat (6) @(negedge CLK_400M);
		check_job(n);
		expect_tag1 = !expect_tag1;
	endtask

	// ----------------------------------------
	task automatic check_reset_quiet();
		repeat (10) begin
			@(negedge CLK_400M);
			if (cor_tx_rd_valid || cor_tx_wr_valid) begin
				report_failure("request issued while idle after reset");
			end
		end
	endtask

	task automatic poll_miss();
		run_job(2, make_handshake(1'b0, 1'b0, 9'd2), 5, 1'b0);
	endtask

	// expecting tag1 here, so a tag0-only handshake must miss
	task automatic tag_alternation();
		run_job(3, make_handshake(1'b1, 1'b0, 9'd3), 4, 1'b0);
	endtask

	task automatic batch_load();
		run_job(8, '0, 0, 1'b1);
	endtask

	task automatic back_pressure();
		bp_enable = 1'b1;
		run_job(16, '0, 0, 1'b0);
		bp_enable = 1'b0;
	endtask

	task automatic zero_batch();
		run_job(0, '0, 0, 1'b1);
	endtask

	initial begin
		reset_n = 1'b0;
		core_start = 1'b0;
		spl_tx_rd_almostfull = 1'b0;
		spl_tx_wr_almostfull = 1'b0;
		io_rx_rd_valid = 1'b0;
		io_rx_data = '0;
		io_src_ptr = SRC_PTR;
		io_dst_ptr = DST_PTR;
		hs_line = '0;
		expect_tag1 = 1'b0;
		bp_enable = 1'b0;
		delay_state = 64'd6165;
		bp_state = xorshift64(64'd6165);
		cycle = 0;
		value_errors = 0;
		other_errors = 0;
		fork
			host_model();
			drive_backpressure();
		join_none
		repeat (2) @(negedge CLK_400M);
		reset_n = 1'b1;
		check_reset_quiet();
		poll_miss();
		tag_alternation();
		batch_load();
		back_pressure();
		zero_batch();
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Error: watchdog expired before the tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+source
source/afu_core_pkg.sv
source/handshake_decode.sv
source/batch_sequencer.sv
source/line_buffer.sv
source/result_writer.sv
source/afu_core.sv
dv/afu_core_properties.sv
dv/afu_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module afu_core_tb -f flist.f

# the grep decides the exit status of the pipeline
./obj_dir/Vafu_core_tb | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null
echo "simulation passed"

// ==== source/afu_core.sv ====
// top of the batch staging and loopback core
// connects decode, sequencer, line buffer and result stage to the host ports
`timescale 1ns/1ps
`default_nettype none

module afu_core import afu_core_pkg::*; (
	input  wire               CLK_400M,
	input  wire               reset_n,
	input  wire               core_start,
	input  wire               spl_tx_rd_almostfull,
	input  wire               spl_tx_wr_almostfull,
	input  wire               io_rx_rd_valid,
	input  wire cache_line_t  io_rx_data,
	input  wire line_addr_t   io_src_ptr,
	input  wire line_addr_t   io_dst_ptr,
	output logic              cor_tx_rd_valid,
	output line_addr_t        cor_tx_rd_addr,
	output logic              cor_tx_wr_valid,
	output logic              cor_tx_fence_valid,
	output line_addr_t        cor_tx_wr_addr,
	output cache_line_t       cor_tx_data
);

	logic         poll_check;
	logic         batch_start;
	logic         poll_miss;
	batch_size_t  batch_size;
	logic         load_active;
	logic         output_start;
	logic         output_done;
	line_count_t  fill_count;
	line_count_t  rd_index;
	cache_line_t  rd_data;

	handshake_decode decode0 (
		.CLK_400M       (CLK_400M),
		.reset_n        (reset_n),
		.poll_check     (poll_check),
		.io_rx_rd_valid (io_rx_rd_valid),
		.io_rx_data     (io_rx_data),
		.batch_start    (batch_start),
		.poll_miss      (poll_miss),
		.batch_size     (batch_size)
	);

	batch_sequencer seq0 (
		.CLK_400M             (CLK_400M),
		.reset_n              (reset_n),
		.core_start           (core_start),
		.spl_tx_rd_almostfull (spl_tx_rd_almostfull),
		.io_src_ptr           (io_src_ptr),
		.batch_start          (batch_start),
		.poll_miss            (poll_miss),
		.batch_size           (batch_size),
		.fill_count           (fill_count),
		.output_done          (output_done),
		.poll_check           (poll_check),
		.load_active          (load_active),
		.output_start         (output_start),
		.cor_tx_rd_valid      (cor_tx_rd_valid),
		.cor_tx_rd_addr       (cor_tx_rd_addr)
	);

	line_buffer buf0 (
		.CLK_400M       (CLK_400M),
		.reset_n        (reset_n),
		.batch_start    (batch_start),
		.load_active    (load_active),
		.io_rx_rd_valid (io_rx_rd_valid),
		.io_rx_data     (io_rx_data),
		.rd_index       (rd_index),
		.fill_count     (fill_count),
		.rd_data        (rd_data)
	);

	result_writer wr0 (
		.CLK_400M             (CLK_400M),
		.reset_n              (reset_n),
		.output_start         (output_start),
		.spl_tx_wr_almostfull (spl_tx_wr_almostfull),
		.batch_size           (batch_size),
		.io_src_ptr           (io_src_ptr),
		.io_dst_ptr           (io_dst_ptr),
		.rd_data              (rd_data),
		.rd_index             (rd_index),
		.output_done          (output_done),
		.cor_tx_wr_valid      (cor_tx_wr_valid),
		.cor_tx_fence_valid   (cor_tx_fence_valid),
		.cor_tx_wr_addr       (cor_tx_wr_addr),
		.cor_tx_data          (cor_tx_data)
	);

endmodule

`default_nettype wire

// ==== source/afu_core_macros.svh ====
// sizes, host memory offsets and handshake bit positions for the staging core
// include wherever a size or an offset is needed
`ifndef AFU_CORE_MACROS_SVH
`define AFU_CORE_MACROS_SVH

// ----------------------------------------
// line buffer geometry
`define CL_WIDTH        512
`define MAX_READ        256
`define LINES_PER_READ  4
`define BUF_DEPTH       (`MAX_READ * `LINES_PER_READ)
`define BATCH_WIDTH     9
`define COUNT_WIDTH     11

// ----------------------------------------
// host address map, in cache lines above io_src_ptr
`define ADDR_WIDTH      58
`define INPUT_OFFSET    (50331648 + 16384)
`define HAND_OFFSET     (`INPUT_OFFSET - 1)

// handshake line layout
`define TAG0_BIT        480
`define TAG1_BIT        482
`define BATCH_LSB       448

// completion word, top bits of the handshake line
`define DONE_CODE       16
`define DONE_WIDTH      32

`define SETTLE_CYCLES   3

`endif

// ==== source/afu_core_pkg.sv ====
// shared types of the staging core
// compile first, modules import it in their headers
`default_nettype none

`include "afu_core_macros.svh"

package afu_core_pkg;

	// handshake view of a polled line, msb first
	typedef struct packed {
		logic [`CL_WIDTH-`TAG1_BIT-2:0]                 upper;
		logic                                           tag1;
		logic [`TAG1_BIT-`TAG0_BIT-2:0]                 rsvd_tag;
		logic                                           tag0;
		logic [`TAG0_BIT-`BATCH_LSB-`BATCH_WIDTH-1:0]   rsvd_mid;
		logic [`BATCH_WIDTH-1:0]                        batch_size;
		logic [`BATCH_LSB-1:0]                          lower;
	} handshake_t;

	// one response word, raw or as a handshake
	typedef union packed {
		logic [`CL_WIDTH-1:0] raw;
		handshake_t           hs;
	} cache_line_t;

	// ninth bit for a full batch of 256
	typedef logic [`BATCH_WIDTH-1:0] batch_size_t;

	typedef logic [`COUNT_WIDTH-1:0] line_count_t;

	typedef logic [`ADDR_WIDTH-1:0] line_addr_t;

endpackage

`default_nettype wire

// ==== source/batch_sequencer.sv ====
// job FSM of the core: settle, poll the handshake, load the batch,
// then hand over to the result stage
`timescale 1ns/1ps
`default_nettype none

`include "afu_core_macros.svh"

module batch_sequencer import afu_core_pkg::*; (
	input  wire               CLK_400M,
	input  wire               reset_n,
	input  wire               core_start,
	input  wire               spl_tx_rd_almostfull,
	input  wire line_addr_t   io_src_ptr,
	input  wire               batch_start,
	input  wire               poll_miss,
	input  wire batch_size_t  batch_size,
	input  wire line_count_t  fill_count,
	input  wire               output_done,
	output logic              poll_check,
	output logic              load_active,
	output logic              output_start,
	output logic              cor_tx_rd_valid,
	output line_addr_t        cor_tx_rd_addr
);

	localparam logic [2:0] S_IDLE   = 3'd0;
	localparam logic [2:0] S_SETTLE = 3'd1;
	localparam logic [2:0] S_POLL   = 3'd2;
	localparam logic [2:0] S_CHECK  = 3'd3;
	localparam logic [2:0] S_LOAD   = 3'd4;
	localparam logic [2:0] S_OUTPUT = 3'd5;

	localparam int SETTLE_W = $clog2(`SETTLE_CYCLES + 1);
	localparam logic [SETTLE_W-1:0] SETTLE_LAST = SETTLE_W'(`SETTLE_CYCLES - 1);

	logic [2:0]           state;
	logic [SETTLE_W-1:0]  settle_cnt;
	line_count_t          issued;
	line_count_t          line_total;
	line_addr_t           hand_addr;
	line_addr_t           input_base;
	logic                 poll_issue;
	logic                 load_issue;

	assign hand_addr = io_src_ptr + line_addr_t'(`HAND_OFFSET);
	assign input_base = io_src_ptr + line_addr_t'(`INPUT_OFFSET);
	assign line_total = line_count_t'(batch_size) * line_count_t'(`LINES_PER_READ);

	assign poll_check = (state == S_CHECK);
	assign load_active = (state == S_LOAD);

	// one read per cycle at most, none under almost-full
	assign poll_issue = (state == S_POLL) && !spl_tx_rd_almostfull;
	assign load_issue = load_active && (issued != line_total) && !spl_tx_rd_almostfull;

	// ----------------------------------------
	// job phases
	always_ff @(posedge CLK_400M) begin
		if (!reset_n) begin
			state <= S_IDLE;
			settle_cnt <= '0;
			issued <= '0;
			output_start <= 1'b0;
			cor_tx_rd_valid <= 1'b0;
		end else begin
			output_start <= 1'b0;
			cor_tx_rd_valid <= poll_issue || load_issue;
			case (state)
				S_IDLE: begin
					if (core_start) begin
						settle_cnt <= '0;
						state <= S_SETTLE;
					end
				end
				S_SETTLE: begin
					settle_cnt <= settle_cnt + SETTLE_W'(1);
					if (settle_cnt == SETTLE_LAST) begin
						state <= S_POLL;
					end
				end
				S_POLL: begin
					if (poll_issue) begin
						state <= S_CHECK;
					end
				end
				S_CHECK: begin
					if (batch_start) begin
						issued <= '0;
						state <= S_LOAD;
					end else if (poll_miss) begin
						state <= S_POLL;
					end
				end
				S_LOAD: begin
					if (load_issue) begin
						issued <= issued + line_count_t'(1);
					end else if (issued == line_total && fill_count == line_total) begin
						// all lines requested and back in the buffer
						output_start <= 1'b1;
						state <= S_OUTPUT;
					end
				end
				S_OUTPUT: begin
					if (output_done) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// read address, only meaningful with the valid
	always_ff @(posedge CLK_400M) begin
		if (poll_issue) begin
			cor_tx_rd_addr <= hand_addr;
		end else if (load_issue) begin
			cor_tx_rd_addr <= input_base + line_addr_t'(issued);
		end
	end

endmodule

`default_nettype wire

// ==== source/handshake_decode.sv ====
// checks a polled handshake line against the expected tag
// and holds the batch size of the accepted job
`timescale 1ns/1ps
`default_nettype none

`include "afu_core_macros.svh"

module handshake_decode import afu_core_pkg::*; (
	input  wire               CLK_400M,
	input  wire               reset_n,
	input  wire               poll_check,
	input  wire               io_rx_rd_valid,
	input  wire cache_line_t  io_rx_data,
	output logic              batch_start,
	output logic              poll_miss,
	output batch_size_t       batch_size
);

	// host flips between tag0 and tag1 on each job
	logic expect_tag1;
	logic tag_hit;
	logic poll_resp;

	assign poll_resp = poll_check && io_rx_rd_valid;
	assign tag_hit = expect_tag1 ? io_rx_data.raw[`TAG1_BIT] : io_rx_data.raw[`TAG0_BIT];

	always_ff @(posedge CLK_400M) begin
		if (!reset_n) begin
			expect_tag1 <= 1'b0;
			batch_start <= 1'b0;
			poll_miss <= 1'b0;
		end else begin
			batch_start <= poll_resp && tag_hit;
			poll_miss <= poll_resp && !tag_hit;
			if (poll_resp && tag_hit) begin
				expect_tag1 <= !expect_tag1;
			end
		end
	end

	// size only taken from an accepted handshake
	always_ff @(posedge CLK_400M) begin
		if (poll_resp && tag_hit) begin
			batch_size <= io_rx_data.hs.batch_size;
		end
	end

endmodule

`default_nettype wire

// ==== source/line_buffer.sv ====
// on-chip staging memory for one batch of input lines
// filled in arrival order, read back with one cycle of latency
`timescale 1ns/1ps
`default_nettype none

`include "afu_core_macros.svh"

module line_buffer import afu_core_pkg::*; (
	input  wire               CLK_400M,
	input  wire               reset_n,
	input  wire               batch_start,
	input  wire               load_active,
	input  wire               io_rx_rd_valid,
	input  wire cache_line_t  io_rx_data,
	input  wire line_count_t  rd_index,
	output line_count_t       fill_count,
	output cache_line_t       rd_data
);

	localparam int IDX_W = $clog2(`BUF_DEPTH);

	cache_line_t  mem [`BUF_DEPTH];
	line_count_t  wr_index;
	logic         wr_en;

	assign wr_en = load_active && io_rx_rd_valid;
	assign fill_count = wr_index;

	always_ff @(posedge CLK_400M) begin
		if (!reset_n || batch_start) begin
			wr_index <= '0;
		end else if (wr_en) begin
			wr_index <= wr_index + line_count_t'(1);
		end
	end

	always_ff @(posedge CLK_400M) begin
		if (wr_en) begin
			mem[wr_index[IDX_W-1:0]] <= io_rx_data;
		end
		rd_data <= mem[rd_index[IDX_W-1:0]];
	end

endmodule

`default_nettype wire

// ==== source/result_writer.sv ====
// writes the staged batch to the destination region, then the fence,
// completion word and closing fence on the handshake line
`timescale 1ns/1ps
`default_nettype none

`include "afu_core_macros.svh"

module result_writer import afu_core_pkg::*; (
	input  wire               CLK_400M,
	input  wire               reset_n,
	input  wire               output_start,
	input  wire               spl_tx_wr_almostfull,
	input  wire batch_size_t  batch_size,
	input  wire line_addr_t   io_src_ptr,
	input  wire line_addr_t   io_dst_ptr,
	input  wire cache_line_t  rd_data,
	output line_count_t       rd_index,
	output logic              output_done,
	output logic              cor_tx_wr_valid,
	output logic              cor_tx_fence_valid,
	output line_addr_t        cor_tx_wr_addr,
	output cache_line_t       cor_tx_data
);

	localparam logic [2:0] W_IDLE   = 3'd0;
	localparam logic [2:0] W_DATA   = 3'd1;
	localparam logic [2:0] W_FENCE1 = 3'd2;
	localparam logic [2:0] W_DONE   = 3'd3;
	localparam logic [2:0] W_FENCE2 = 3'd4;

	logic [2:0]   state;
	line_count_t  wr_ptr;
	line_count_t  next_ptr;
	line_count_t  line_total;
	line_addr_t   hand_addr;
	cache_line_t  done_line;
	logic         data_issue;
	logic         tail_issue;

	assign hand_addr = io_src_ptr + line_addr_t'(`HAND_OFFSET);
	assign line_total = line_count_t'(batch_size) * line_count_t'(`LINES_PER_READ);
	assign done_line.raw = {`DONE_WIDTH'(`DONE_CODE), {(`CL_WIDTH - `DONE_WIDTH){1'b0}}};

	assign data_issue = (state == W_DATA) && (wr_ptr != line_total) && !spl_tx_wr_almostfull;
	assign tail_issue = !spl_tx_wr_almostfull &&
		(state == W_FENCE1 || state == W_DONE || state == W_FENCE2);

	// prefetch: rd_data always holds the line at wr_ptr
	assign next_ptr = wr_ptr + line_count_t'(data_issue);
	assign rd_index = (state == W_DATA) ? next_ptr : '0;

	// ----------------------------------------
	// write sequence
	always_ff @(posedge CLK_400M) begin
		if (!reset_n) begin
			state <= W_IDLE;
			wr_ptr <= '0;
			output_done <= 1'b0;
			cor_tx_wr_valid <= 1'b0;
			cor_tx_fence_valid <= 1'b0;
		end else begin
			output_done <= 1'b0;
			cor_tx_wr_valid <= data_issue || tail_issue;
			cor_tx_fence_valid <= tail_issue && (state != W_DONE);
			case (state)
				W_IDLE: begin
					if (output_start) begin
						wr_ptr <= '0;
						state <= W_DATA;
					end
				end
				W_DATA: begin
					wr_ptr <= next_ptr;
					if (next_ptr == line_total) begin
						state <= W_FENCE1;
					end
				end
				W_FENCE1: begin
					if (tail_issue) begin
						state <= W_DONE;
					end
				end
				W_DONE: begin
					if (tail_issue) begin
						state <= W_FENCE2;
					end
				end
				W_FENCE2: begin
					if (tail_issue) begin
						output_done <= 1'b1;
						state <= W_IDLE;
					end
				end
				default: state <= W_IDLE;
			endcase
		end
	end

	// write address and data
	always_ff @(posedge CLK_400M) begin
		if (data_issue) begin
			cor_tx_wr_addr <= io_dst_ptr + line_addr_t'(wr_ptr);
			cor_tx_data <= rd_data;
		end else if (tail_issue) begin
			cor_tx_wr_addr <= hand_addr;
			if (state == W_DONE) begin
				cor_tx_data <= done_line;
			end else begin
				cor_tx_data <= '0;
			end
		end
	end

endmodule

`default_nettype wire
